//--- rv32_mini_core.f
rv32_isa_pkg.sv
core_uarch_pkg.sv
pc_unit.sv
inst_decoder.sv
reg_file.sv
alu_exec.sv
core_top.sv
tb_clk_gen.sv
tb_core_top.sv

//--- tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;
	import rv32_isa_pkg::*;
	import core_uarch_pkg::*;

	localparam addr_t RESET_PC        = 32'h8000_0000;
	localparam int    PROG_WORDS      = 64;
	localparam int    TIMEOUT_CYCLES  = PROG_WORDS * 4 + 50;
	localparam int    POST_HALT_CYCLES = 8;

	logic     clk;
	logic     arst_n;
	addr_t    fetch_addr;
	word_t    inst;
	logic     invalid;
	logic     halted;
	logic     retire;
	retire_t  retire_data;

	// program image and reference state
	word_t        mem [PROG_WORDS];
	word_t        ref_regs [NUM_REGS];
	addr_t        ref_pc;
	logic [15:0]  lfsr_state;
	int           exp_retires;
	int           dut_retires = 0;
	int           cycle_count = 0;

	tb_clk_gen #(
		.PERIOD_NS    (10),
		.RESET_CYCLES (4)
	) u_clk_gen (
		.clk      (clk),
		.arst_n_o (arst_n)
	);

	core_top #(
		.RESET_PC (RESET_PC)
	) UUT (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.fetch_addr_o  (fetch_addr),
		.inst_i        (inst),
		.invalid_o     (invalid),
		.halted_o      (halted),
		.retire_o      (retire),
		.retire_data_o (retire_data)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	// galois lfsr, x^16+x^14+x^13+x^11+1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 16'hB400;
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	// memory wraps every 64 words
	function automatic logic [5:0] word_index(input addr_t a);
		addr_t off;
		off = a - RESET_PC;
		return off[7:2];
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t enc_j(input word_t off, input reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	// RV32I semantics for OP and OP-IMM
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
			input word_t x, input word_t y);
		case (f3)
			F3_ADD_SUB: begin
				if (alt)
					return x - y;
				return x + y;
			end
			F3_SLL:  return x << y[4:0];
			F3_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			F3_SLTU: return (x < y) ? 32'd1 : 32'd0;
			F3_XOR:  return x ^ y;
			F3_SR: begin
				if (alt)
					return $signed(x) >>> y[4:0];
				return x >> y[4:0];
			end
			F3_OR:   return x | y;
			default: return x & y;
		endcase
	endfunction

	// one instruction on the reference state, returns the expected trace
	function automatic retire_t ref_step(input word_t word, output logic exp_inv,
			output logic exp_brk);
		retire_t     r;
		logic [2:0]  f3;
		logic [6:0]  f7;
		reg_idx_t    rd;
		word_t       a;
		word_t       b;
		word_t       imm_i;
		word_t       imm_j;
		word_t       res;
		addr_t       nxt;
		logic        wr;
		f3 = word[14:12];
		f7 = word[31:25];
		rd = word[11:7];
		a = ref_regs[word[19:15]];
		b = ref_regs[word[24:20]];
		imm_i = {{20{word[31]}}, word[31:20]};
		imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		res = '0;
		wr = 1'b0;
		exp_inv = 1'b0;
		exp_brk = 1'b0;
		nxt = ref_pc + 32'd4;
		case (word[6:0])
			OPC_LUI: begin
				wr = 1'b1;
				res = {word[31:12], 12'b0};
			end
			OPC_AUIPC: begin
				wr = 1'b1;
				res = ref_pc + {word[31:12], 12'b0};
			end
			OPC_JAL: begin
				wr = 1'b1;
				res = ref_pc + 32'd4;
				nxt = (ref_pc + imm_j) & ~32'd3;
			end
			OPC_JALR: begin
				exp_inv = (f3 != 3'b000);
				wr = !exp_inv;
				res = ref_pc + 32'd4;
				if (!exp_inv)
					nxt = (a + imm_i) & ~32'd3;
			end
			OPC_OP_IMM: begin
				// shift immediates carry funct7 in imm[11:5]
				if (f3 == F3_SLL)
					exp_inv = (f7 != F7_BASE);
				else if (f3 == F3_SR)
					exp_inv = (f7 != F7_BASE) && (f7 != F7_ALT);
				wr = !exp_inv;
				res = alu_ref(f3, (f3 == F3_SR) && (f7 == F7_ALT), a, imm_i);
			end
			OPC_OP: begin
				exp_inv = !((f7 == F7_BASE) ||
					((f7 == F7_ALT) && ((f3 == F3_ADD_SUB) || (f3 == F3_SR))));
				wr = !exp_inv;
				res = alu_ref(f3, f7 == F7_ALT, a, b);
			end
			OPC_SYSTEM: begin
				exp_brk = (word == EBREAK_WORD);
				exp_inv = !exp_brk;
				if (exp_brk)
					nxt = ref_pc;
			end
			default: exp_inv = 1'b1;
		endcase
		if (!wr)
			res = '0;
		r.pc = ref_pc;
		r.inst = word;
		r.rd_we = wr;
		r.rd = wr ? rd : '0;
		r.wdata = res;
		// x0 stays zero
		if (wr && (rd != '0))
			ref_regs[rd] = res;
		ref_pc = nxt;
		return r;
	endfunction

	// program generation and a dry reference run for the retire count
	initial begin : build_program
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [2:0]  f3;
		logic [4:0]  sh;
		logic [11:0] imm12;
		int          i;
		int          t;
		logic        inv;
		logic        brk;
		retire_t     dummy;
		inst = '0;
		lfsr_state = 16'd55398;
		// x31 holds the program base for every jalr
		mem[0] = {RESET_PC[31:12], 5'd31, OPC_LUI};
		mem[PROG_WORDS-1] = EBREAK_WORD;
		i = 1;
		while (i < PROG_WORDS - 1) begin
			// x0..x7 only, x0 shows up often
			rd = reg_idx_t'(take_bits(3));
			rs1 = reg_idx_t'(take_bits(3));
			rs2 = reg_idx_t'(take_bits(3));
			f3 = 3'(take_bits(3));
			sh = 5'(take_bits(5));
			case (3'(take_bits(3)))
				3'd0: begin
					if (take_bits(1) != 0)
						mem[i] = {20'(take_bits(20)), rd, OPC_LUI};
					else
						mem[i] = {20'(take_bits(20)), rd, OPC_AUIPC};
				end
				3'd1, 3'd7: begin
					if (f3 == F3_SLL)
						imm12 = {F7_BASE, sh};
					else if (f3 == F3_SR)
						imm12 = {(take_bits(1) != 0) ? F7_ALT : F7_BASE, sh};
					else
						imm12 = 12'(take_bits(12));
					mem[i] = enc_i(imm12, rs1, f3, rd, OPC_OP_IMM);
				end
				3'd2, 3'd3: begin
					if (((f3 == F3_ADD_SUB) || (f3 == F3_SR)) && (take_bits(1) != 0))
						mem[i] = enc_r(F7_ALT, rs2, rs1, f3, rd);
					else
						mem[i] = enc_r(F7_BASE, rs2, rs1, f3, rd);
				end
				3'd4: begin
					// forward only, so the program always reaches ebreak
					t = i + 1 + int'(take_bits(2));
					if (t > PROG_WORDS - 1)
						t = PROG_WORDS - 1;
					mem[i] = enc_j(32'(4 * (t - i)), rd);
				end
				3'd5: begin
					// absolute target off x31, low bits random to test clearing
					t = i + 1 + int'(take_bits(2));
					if (t > PROG_WORDS - 1)
						t = PROG_WORDS - 1;
					imm12 = 12'(4 * t) | 12'(take_bits(2));
					mem[i] = enc_i(imm12, 5'd31, 3'b000, rd, OPC_JALR);
				end
				default: begin
					case (2'(take_bits(2)))
						// load opcode, not part of the core
						2'd0: mem[i] = {25'(take_bits(25)), 7'b0000011};
						2'd1: mem[i] = enc_r(7'h01, rs2, rs1, f3, rd);
						// ecall
						2'd2: mem[i] = 32'h0000_0073;
						default: mem[i] = enc_i({F7_ALT, sh}, rs1, F3_SLL, rd, OPC_OP_IMM);
					endcase
				end
			endcase
			i++;
		end
		foreach (ref_regs[j])
			ref_regs[j] = '0;
		ref_pc = RESET_PC;
		exp_retires = 0;
		brk = 1'b0;
		while (!brk && (exp_retires < TIMEOUT_CYCLES)) begin
			dummy = ref_step(mem[word_index(ref_pc)], inv, brk);
			exp_retires++;
		end
		// restart reference for the live comparison
		foreach (ref_regs[j])
			ref_regs[j] = '0;
		ref_pc = RESET_PC;
	end

	// memory answers the current pc on the falling edge
	always @(negedge clk) begin
		inst = mem[word_index(fetch_addr)];
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("timeout after %0d cycles, the core never halted", cycle_count));
	end

	// sample mid low phase, after the new instruction has settled
	initial begin : compare_retires
		retire_t  exp;
		logic     exp_inv;
		logic     exp_brk;
		logic     started;
		logic     done;
		int       post_halt;
		addr_t    halt_pc;
		started = 1'b0;
		done = 1'b0;
		post_halt = 0;
		halt_pc = '0;
		while (post_halt < POST_HALT_CYCLES) begin
			@(negedge clk);
			#2;
			if (!arst_n) begin
				assert (!retire && !halted) else
					abort_run($sformatf("FAILED at %0t: retire or halted high in reset", $time));
			end else if (done) begin
				assert (!retire) else
					abort_run($sformatf("FAILED at %0t: retire after ebreak", $time));
				assert (halted) else
					abort_run($sformatf("FAILED at %0t: halted low after ebreak", $time));
				assert (fetch_addr == halt_pc) else
					abort_run($sformatf("FAILED at %0t: pc moved to %h in halt", $time,
						fetch_addr));
				post_halt++;
			end else if (retire) begin
				started = 1'b1;
				dut_retires++;
				// reference fetches from its own pc
				exp = ref_step(mem[word_index(ref_pc)], exp_inv, exp_brk);
				assert (retire_data == exp) else
					abort_run({
						$sformatf("FAILED at %0t: got pc %h inst %h we %b rd x%0d wdata %h",
							$time, retire_data.pc, retire_data.inst, retire_data.rd_we,
							retire_data.rd, retire_data.wdata),
						$sformatf(", expected pc %h inst %h we %b rd x%0d wdata %h",
							exp.pc, exp.inst, exp.rd_we, exp.rd, exp.wdata)});
				assert (invalid == exp_inv) else
					abort_run($sformatf("FAILED at %0t: invalid %b for inst %h, expected %b",
						$time, invalid, exp.inst, exp_inv));
				assert (!halted) else
					abort_run($sformatf("FAILED at %0t: halted while retiring", $time));
				if (exp_brk) begin
					done = 1'b1;
					halt_pc = exp.pc;
				end
			end else begin
				assert (!started) else
					abort_run($sformatf("FAILED at %0t: retire dropped before ebreak", $time));
			end
		end
		if (dut_retires == exp_retires) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run($sformatf("FAILED at %0t: %0d retires, reference expects %0d", $time,
				dut_retires, exp_retires));
		end
	end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic arst_n_o
);

	// free running, low at time zero
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// high for a moment so the async reset sees a clean falling edge
	// release on a falling edge, away from the sampling edge
	initial begin
		arst_n_o = 1'b1;
		#1;
		arst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
	parameter rv32_isa_pkg::addr_t RESET_PC = 32'h8000_0000
) (
	input  logic                     clk,
	input  logic                     arst_n_i,
	output rv32_isa_pkg::addr_t      fetch_addr_o,
	input  rv32_isa_pkg::word_t      inst_i,
	output logic                     invalid_o,
	output logic                     halted_o,
	output logic                     retire_o,
	output core_uarch_pkg::retire_t  retire_data_o
);
	import rv32_isa_pkg::*;
	import core_uarch_pkg::*;

	addr_t  pc;
	addr_t  jalr_target;
	logic   run;
	logic   rd_we;
	dec_t   dec;
	word_t  rs1_val;
	word_t  rs2_val;
	word_t  result;

	pc_unit #(
		.RESET_PC (RESET_PC)
	) u_pc_unit (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.is_jal_i      (dec.is_jal),
		.is_jalr_i     (dec.is_jalr),
		.is_ebreak_i   (dec.is_ebreak),
		.imm_i         (dec.imm),
		.jalr_target_i (jalr_target),
		.pc_o          (pc),
		.run_o         (run),
		.halted_o      (halted_o)
	);

	inst_decoder u_inst_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	// writes only land in RUN cycles
	assign rd_we = dec.rd_we & run;

	reg_file u_reg_file (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.we_i     (rd_we),
		.waddr_i  (dec.rd),
		.raddr1_i (dec.rs1),
		.raddr2_i (dec.rs2),
		.wdata_i  (result),
		.rdata1_o (rs1_val),
		.rdata2_o (rs2_val)
	);

	alu_exec u_alu_exec (
		.dec_i         (dec),
		.pc_i          (pc),
		.rs1_val_i     (rs1_val),
		.rs2_val_i     (rs2_val),
		.result_o      (result),
		.jalr_target_o (jalr_target)
	);

	assign fetch_addr_o = pc;
	// one retire per RUN cycle
	assign retire_o  = run;
	assign invalid_o = dec.invalid & run;

	// trace, rd and wdata zero when nothing is written
	assign retire_data_o.pc    = pc;
	assign retire_data_o.inst  = inst_i;
	assign retire_data_o.rd_we = rd_we;
	assign retire_data_o.rd    = rd_we ? dec.rd : '0;
	assign retire_data_o.wdata = rd_we ? result : '0;

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
	input  core_uarch_pkg::dec_t  dec_i,
	input  rv32_isa_pkg::addr_t   pc_i,
	input  rv32_isa_pkg::word_t   rs1_val_i,
	input  rv32_isa_pkg::word_t   rs2_val_i,
	output rv32_isa_pkg::word_t   result_o,
	output rv32_isa_pkg::addr_t   jalr_target_o
);
	import rv32_isa_pkg::*;
	import core_uarch_pkg::*;

	word_t                 op_a;
	word_t                 op_b;
	word_t                 alu_res;
	word_t                 link_addr;
	logic [REG_IDX_W-1:0]  shamt;

	// operand muxes
	assign op_a = dec_i.use_pc_a ? pc_i : rs1_val_i;
	assign op_b = (dec_i.src_b_sel == SRC_B_IMM) ? dec_i.imm : rs2_val_i;
	// shifts use only low 5 bits
	assign shamt = op_b[REG_IDX_W-1:0];

	always_comb begin
		case (dec_i.alu_op)
			ALU_ADD:  alu_res = op_a + op_b;
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << shamt;
			ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'b0, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> shamt;
			ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
			ALU_OR:   alu_res = op_a | op_b;
			default:  alu_res = op_a & op_b;
		endcase
	end

	// return address for jal and jalr
	assign link_addr = pc_i + 32'd4;

	// writeback select
	always_comb begin
		case (dec_i.res_src)
			RES_LINK: result_o = link_addr;
			RES_IMM:  result_o = dec_i.imm;
			default:  result_o = alu_res;
		endcase
	end

	// low bits cleared later in pc_unit
	assign jalr_target_o = rs1_val_i + dec_i.imm;

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    we_i,
	input  rv32_isa_pkg::reg_idx_t  waddr_i,
	input  rv32_isa_pkg::reg_idx_t  raddr1_i,
	input  rv32_isa_pkg::reg_idx_t  raddr2_i,
	input  rv32_isa_pkg::word_t     wdata_i,
	output rv32_isa_pkg::word_t     rdata1_o,
	output rv32_isa_pkg::word_t     rdata2_o
);
	import rv32_isa_pkg::*;

	word_t regs_q [NUM_REGS];

	// x0 is never written so it keeps its reset value
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// async reads, same-cycle write not visible
	assign rdata1_o = regs_q[raddr1_i];
	assign rdata2_o = regs_q[raddr2_i];

	// x0 reads zero on both ports even after writes aimed at it
	a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
		(raddr1_i != '0 || rdata1_o == '0) && (raddr2_i != '0 || rdata2_o == '0));

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  rv32_isa_pkg::word_t    inst_i,
	output core_uarch_pkg::dec_t   dec_o
);
	import rv32_isa_pkg::*;
	import core_uarch_pkg::*;

	opcode_t              opcode;
	logic [FUNCT3_W-1:0]  funct3;
	logic [FUNCT7_W-1:0]  funct7;
	word_t                imm_i_type;
	word_t                imm_u_type;
	word_t                imm_j_type;
	dec_t                 dec;

	// raw fields
	assign opcode = opcode_t'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// sign-extended I immediate
	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	// upper immediate, low 12 bits zero
	assign imm_u_type = {inst_i[31:12], 12'b0};
	// J immediate, scattered bits, bit 0 always zero
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		dec           = '0;
		dec.alu_op    = ALU_ADD;
		dec.res_src   = RES_ALU;
		dec.src_b_sel = SRC_B_REG;
		dec.rd        = inst_i[11:7];
		dec.rs1       = inst_i[19:15];
		dec.rs2       = inst_i[24:20];
		case (opcode)
			OPC_LUI: begin
				dec.rd_we   = 1'b1;
				dec.res_src = RES_IMM;
				dec.imm     = imm_u_type;
			end
			OPC_AUIPC: begin
				// pc + upper immediate through the adder
				dec.rd_we     = 1'b1;
				dec.use_pc_a  = 1'b1;
				dec.src_b_sel = SRC_B_IMM;
				dec.imm       = imm_u_type;
			end
			OPC_JAL: begin
				dec.rd_we   = 1'b1;
				dec.res_src = RES_LINK;
				dec.imm     = imm_j_type;
				dec.is_jal  = 1'b1;
			end
			OPC_JALR: begin
				dec.rd_we   = 1'b1;
				dec.res_src = RES_LINK;
				dec.imm     = imm_i_type;
				dec.is_jalr = 1'b1;
				// only funct3 000 is defined
				dec.invalid = (funct3 != F3_ADD_SUB);
			end
			OPC_OP_IMM: begin
				dec.rd_we     = 1'b1;
				dec.src_b_sel = SRC_B_IMM;
				dec.imm       = imm_i_type;
				case (funct3)
					F3_ADD_SUB: dec.alu_op = ALU_ADD;
					F3_SLT:     dec.alu_op = ALU_SLT;
					F3_SLTU:    dec.alu_op = ALU_SLTU;
					F3_XOR:     dec.alu_op = ALU_XOR;
					F3_OR:      dec.alu_op = ALU_OR;
					F3_AND:     dec.alu_op = ALU_AND;
					F3_SLL: begin
						dec.alu_op  = ALU_SLL;
						dec.invalid = (funct7 != F7_BASE);
					end
					// srli or srai by funct7, anything else illegal
					default: begin
						dec.alu_op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
						dec.invalid = (funct7 != F7_BASE) && (funct7 != F7_ALT);
					end
				endcase
			end
			OPC_OP: begin
				dec.rd_we = 1'b1;
				case (funct3)
					F3_ADD_SUB: dec.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
					F3_SLL:     dec.alu_op = ALU_SLL;
					F3_SLT:     dec.alu_op = ALU_SLT;
					F3_SLTU:    dec.alu_op = ALU_SLTU;
					F3_XOR:     dec.alu_op = ALU_XOR;
					F3_SR:      dec.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
					F3_OR:      dec.alu_op = ALU_OR;
					default:    dec.alu_op = ALU_AND;
				endcase
				// alt funct7 exists only for sub and sra
				if (funct7 == F7_ALT) begin
					dec.invalid = (funct3 != F3_ADD_SUB) && (funct3 != F3_SR);
				end else begin
					dec.invalid = (funct7 != F7_BASE);
				end
			end
			OPC_SYSTEM: begin
				dec.is_ebreak = (inst_i == EBREAK_WORD);
				dec.invalid   = (inst_i != EBREAK_WORD);
			end
			default: dec.invalid = 1'b1;
		endcase
		// illegal words retire as plain pc+4
		if (dec.invalid) begin
			dec.rd_we   = 1'b0;
			dec.is_jal  = 1'b0;
			dec.is_jalr = 1'b0;
		end
	end

	assign dec_o = dec;

endmodule

`default_nettype wire

//--- pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
	parameter rv32_isa_pkg::addr_t RESET_PC = 32'h8000_0000
) (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 is_jal_i,
	input  logic                 is_jalr_i,
	input  logic                 is_ebreak_i,
	input  rv32_isa_pkg::word_t  imm_i,
	input  rv32_isa_pkg::addr_t  jalr_target_i,
	output rv32_isa_pkg::addr_t  pc_o,
	output logic                 run_o,
	output logic                 halted_o
);
	import rv32_isa_pkg::*;

	typedef enum logic [1:0] {
		ST_RESET,
		ST_RUN,
		ST_HALT
	} state_t;

	state_t state_q;
	state_t state_d;
	addr_t  pc_q;
	addr_t  pc_d;
	addr_t  jal_target;

	// pc-relative jump target before alignment
	assign jal_target = pc_q + imm_i;

	always_comb begin
		state_d = state_q;
		pc_d    = pc_q;
		case (state_q)
			// first edge after reset only starts the run
			ST_RESET: state_d = ST_RUN;
			ST_RUN: begin
				if (is_ebreak_i) begin
					// pc stays on the ebreak
					state_d = ST_HALT;
				end else if (is_jal_i) begin
					pc_d = {jal_target[31:2], 2'b00};
				end else if (is_jalr_i) begin
					pc_d = {jalr_target_i[31:2], 2'b00};
				end else begin
					pc_d = pc_q + 32'd4;
				end
			end
			ST_HALT: state_d = ST_HALT;
			default: state_d = ST_RESET;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_RESET;
			pc_q    <= RESET_PC;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
		end
	end

	assign pc_o     = pc_q;
	assign run_o    = (state_q == ST_RUN);
	assign halted_o = (state_q == ST_HALT);

	// fetch address stays word aligned whatever the jalr operands were
	a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
		pc_q[1:0] == 2'b00);

	// halt is final and freezes the pc
	a_halt_holds: assert property (@(posedge clk) disable iff (!arst_n_i)
		state_q == ST_HALT |=> state_q == ST_HALT && $stable(pc_q));

endmodule

`default_nettype wire

//--- core_uarch_pkg.sv
`default_nettype none

package core_uarch_pkg;

	// ALU functions, shared by OP and OP-IMM
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_t;

	// writeback value source
	typedef enum logic [1:0] {
		RES_ALU,
		RES_LINK,
		RES_IMM
	} res_src_t;

	// second ALU operand
	typedef enum logic {
		SRC_B_REG,
		SRC_B_IMM
	} src_b_sel_t;

	// decoder output bundle
	typedef struct packed {
		alu_op_t                 alu_op;
		res_src_t                res_src;
		src_b_sel_t              src_b_sel;
		// auipc takes pc as operand a
		logic                    use_pc_a;
		logic                    rd_we;
		rv32_isa_pkg::reg_idx_t  rd;
		rv32_isa_pkg::reg_idx_t  rs1;
		rv32_isa_pkg::reg_idx_t  rs2;
		rv32_isa_pkg::word_t     imm;
		logic                    is_jal;
		logic                    is_jalr;
		logic                    is_ebreak;
		logic                    invalid;
	} dec_t;

	// per-instruction trace, 102 bits
	typedef struct packed {
		rv32_isa_pkg::addr_t     pc;
		rv32_isa_pkg::word_t     inst;
		logic                    rd_we;
		rv32_isa_pkg::reg_idx_t  rd;
		rv32_isa_pkg::word_t     wdata;
	} retire_t;

endpackage

`default_nettype wire

//--- rv32_isa_pkg.sv
`default_nettype none

package rv32_isa_pkg;

	// base integer width and field widths
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 2 ** REG_IDX_W;
	localparam int OPCODE_W  = 7;
	localparam int FUNCT3_W  = 3;
	localparam int FUNCT7_W  = 7;

	// data and instruction word
	typedef logic [XLEN-1:0] word_t;
	// byte address
	typedef logic [XLEN-1:0] addr_t;
	// architectural register index
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// major opcodes of the supported subset
	typedef enum logic [OPCODE_W-1:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	// funct3 for OP and OP-IMM
	localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;
	localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
	localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

	// funct7 values, ALT selects sub and sra
	localparam logic [FUNCT7_W-1:0] F7_BASE = 7'h00;
	localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'h20;

	// the only SYSTEM encoding accepted
	localparam word_t EBREAK_WORD = 32'h0010_0073;

endpackage

`default_nettype wire
